// ==== include/exu_config.svh ====
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// Datapath width of every register and result
`define EXU_XLEN 32

// Register bank depth, index width is fixed at 4 bits
`define EXU_NREGS 16

// Multiply pipe depth, one stage per cycle
`define EXU_MUL_STAGES 5

`endif

// ==== verilog/exu_pkg.sv ====
`include "exu_config.svh"

package exu_pkg;

  typedef logic [`EXU_XLEN-1:0] data_t;
  typedef logic [3:0]           reg_idx_t;
  typedef logic [15:0]          imm_t;
  typedef logic [3:0]           wb_addr_t;

  // Opcode field of the operation word, bits 31 to 28
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_LI  = 4'd5,
    OP_MUL = 4'd6,
    OP_NOP = 4'd7
  } opcode_t;

endpackage

// ==== verilog/exu_wb_slave.sv ====
`timescale 1ns/1ps

module exu_wb_slave (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  exu_pkg::wb_addr_t  wb_adr_i,
  input  exu_pkg::data_t     wb_dat_i,
  output exu_pkg::data_t     wb_dat_o,
  output logic               wb_ack_o,
  input  logic               issue_ok_i,
  input  logic               read_ok_i,
  input  exu_pkg::data_t     rd_data_i,
  output logic               issue_valid_o,
  output exu_pkg::opcode_t   opcode_o,
  output exu_pkg::reg_idx_t  rd_o,
  output exu_pkg::reg_idx_t  rs1_o,
  output exu_pkg::reg_idx_t  rs2_o,
  output exu_pkg::imm_t      imm_o,
  output exu_pkg::reg_idx_t  read_idx_o
);
  import exu_pkg::*;

  logic       req;
  logic       accept_wr;
  logic       accept_rd;
  logic [3:0] op_raw;

  // A request is live until its ack has been given
  assign req           = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign issue_valid_o = req && wb_we_i;
  assign accept_wr     = issue_valid_o && issue_ok_i;
  assign accept_rd     = req && !wb_we_i && read_ok_i;

  // Operation word fields
  assign op_raw     = wb_dat_i[31:28];
  assign rd_o       = wb_dat_i[27:24];
  assign rs1_o      = wb_dat_i[23:20];
  assign rs2_o      = wb_dat_i[19:16];
  assign imm_o      = wb_dat_i[15:0];
  assign read_idx_o = reg_idx_t'(wb_adr_i);

  // Unknown opcodes behave as NOP
  always_comb begin
    if (op_raw > 4'(OP_MUL)) begin
      opcode_o = OP_NOP;
    end else begin
      opcode_o = opcode_t'(op_raw);
    end
  end

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= accept_wr || accept_rd;
    end
  end

  // Read data lines up with the ack cycle
  always_ff @(posedge clk_i) begin
    if (accept_rd) begin
      wb_dat_o <= rd_data_i;
    end
  end

endmodule

// ==== verilog/exu_hazard.sv ====
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_hazard (
  input  logic                                    issue_valid_i,
  input  exu_pkg::opcode_t                        opcode_i,
  input  exu_pkg::reg_idx_t                       rd_i,
  input  exu_pkg::reg_idx_t                       rs1_i,
  input  exu_pkg::reg_idx_t                       rs2_i,
  input  exu_pkg::reg_idx_t                       read_idx_i,
  input  logic                                    alu_busy_i,
  input  exu_pkg::reg_idx_t                       alu_rd_i,
  input  logic [`EXU_MUL_STAGES-1:0]              mul_valid_i,
  input  exu_pkg::reg_idx_t [`EXU_MUL_STAGES-1:0] mul_rd_i,
  output logic                                    issue_ok_o,
  output logic                                    read_ok_o
);
  import exu_pkg::*;

  logic [`EXU_NREGS-1:0] pending;
  logic                  alu_path_op;
  logic                  reg_busy;
  logic                  wb_collision;

  // Scoreboard of destinations still in flight
  always_comb begin
    pending = '0;
    if (alu_busy_i) begin
      pending[alu_rd_i] = 1'b1;
    end
    for (int s = 0; s < `EXU_MUL_STAGES; s++) begin
      if (mul_valid_i[s]) begin
        pending[mul_rd_i[s]] = 1'b1;
      end
    end
    // r0 never waits on anything
    pending[0] = 1'b0;
  end

  assign alu_path_op = (opcode_i != OP_MUL) && (opcode_i != OP_NOP);
  assign reg_busy    = pending[rs1_i] || pending[rs2_i] || pending[rd_i];

  // ALU result lands one cycle after issue, same edge as a multiply now in stage four
  assign wb_collision = alu_path_op && mul_valid_i[`EXU_MUL_STAGES-2];

  assign issue_ok_o = issue_valid_i && !reg_busy && !wb_collision;
  assign read_ok_o  = !pending[read_idx_i];

endmodule

// ==== verilog/exu_alu.sv ====
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_alu (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               issue_i,
  input  exu_pkg::opcode_t   opcode_i,
  input  exu_pkg::reg_idx_t  rd_i,
  input  exu_pkg::imm_t      imm_i,
  input  exu_pkg::data_t     a_i,
  input  exu_pkg::data_t     b_i,
  output logic               wb_valid_o,
  output exu_pkg::reg_idx_t  wb_rd_o,
  output exu_pkg::data_t     wb_data_o
);
  import exu_pkg::*;

  logic  alu_op;
  data_t result;

  assign alu_op = (opcode_i != OP_MUL) && (opcode_i != OP_NOP);

  always_comb begin
    case (opcode_i)
      OP_ADD:  result = a_i + b_i;
      OP_SUB:  result = a_i - b_i;
      OP_AND:  result = a_i & b_i;
      OP_OR:   result = a_i | b_i;
      OP_XOR:  result = a_i ^ b_i;
      // Zero-extended immediate
      OP_LI:   result = {{(`EXU_XLEN-$bits(imm_t)){1'b0}}, imm_i};
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= issue_i && alu_op;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      wb_rd_o   <= rd_i;
      wb_data_o <= result;
    end
  end

endmodule

// ==== verilog/exu_mul_pipe.sv ====
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_mul_pipe (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                                    issue_i,
  input  exu_pkg::opcode_t                        opcode_i,
  input  exu_pkg::reg_idx_t                       rd_i,
  input  exu_pkg::data_t                          a_i,
  input  exu_pkg::data_t                          b_i,
  output logic [`EXU_MUL_STAGES-1:0]              stage_valid_o,
  output exu_pkg::reg_idx_t [`EXU_MUL_STAGES-1:0] stage_rd_o,
  output logic                                    wb_valid_o,
  output exu_pkg::reg_idx_t                       wb_rd_o,
  output exu_pkg::data_t                          wb_data_o
);
  import exu_pkg::*;

  logic [`EXU_MUL_STAGES-1:0] valid_q;
  reg_idx_t                   rd_q   [`EXU_MUL_STAGES];
  data_t                      prod_q [`EXU_MUL_STAGES];
  logic                       start;
  data_t                      product;

  assign start   = issue_i && (opcode_i == OP_MUL);
  // Only the low word of the product is kept
  assign product = a_i * b_i;

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[`EXU_MUL_STAGES-2:0], start};
    end
  end

  // Payload shifts every cycle, valid bits qualify it
  always_ff @(posedge clk_i) begin
    rd_q[0]   <= rd_i;
    prod_q[0] <= product;
    for (int s = 1; s < `EXU_MUL_STAGES; s++) begin
      rd_q[s]   <= rd_q[s-1];
      prod_q[s] <= prod_q[s-1];
    end
  end

  always_comb begin
    for (int s = 0; s < `EXU_MUL_STAGES; s++) begin
      stage_rd_o[s] = rd_q[s];
    end
  end

  assign stage_valid_o = valid_q;
  assign wb_valid_o    = valid_q[`EXU_MUL_STAGES-1];
  assign wb_rd_o       = rd_q[`EXU_MUL_STAGES-1];
  assign wb_data_o     = prod_q[`EXU_MUL_STAGES-1];

endmodule

// ==== verilog/exu_regfile.sv ====
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_regfile (
  input  logic               clk_i,
  input  logic               rst_i,
  input  exu_pkg::reg_idx_t  rs1_i,
  input  exu_pkg::reg_idx_t  rs2_i,
  input  exu_pkg::reg_idx_t  dbg_idx_i,
  output exu_pkg::data_t     rs1_data_o,
  output exu_pkg::data_t     rs2_data_o,
  output exu_pkg::data_t     dbg_data_o,
  input  logic               alu_wb_valid_i,
  input  exu_pkg::reg_idx_t  alu_wb_rd_i,
  input  exu_pkg::data_t     alu_wb_data_i,
  input  logic               mul_wb_valid_i,
  input  exu_pkg::reg_idx_t  mul_wb_rd_i,
  input  exu_pkg::data_t     mul_wb_data_i
);
  import exu_pkg::*;

  data_t    regs_q [`EXU_NREGS];
  logic     wr_en;
  reg_idx_t wr_idx;
  data_t    wr_data;

  // Single write port, issue logic keeps the two pipes apart
  always_comb begin
    if (alu_wb_valid_i) begin
      wr_idx  = alu_wb_rd_i;
      wr_data = alu_wb_data_i;
    end else begin
      wr_idx  = mul_wb_rd_i;
      wr_data = mul_wb_data_i;
    end
    wr_en = (alu_wb_valid_i || mul_wb_valid_i) && (wr_idx != '0);
  end

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      for (int i = 0; i < `EXU_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wr_idx] <= wr_data;
    end
  end

  // r0 stays zero since it is never written
  assign rs1_data_o = regs_q[rs1_i];
  assign rs2_data_o = regs_q[rs2_i];
  assign dbg_data_o = regs_q[dbg_idx_i];

endmodule

// ==== verilog/exu_top.sv ====
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_top (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  exu_pkg::wb_addr_t  wb_adr_i,
  input  exu_pkg::data_t     wb_dat_i,
  output exu_pkg::data_t     wb_dat_o,
  output logic               wb_ack_o
);
  import exu_pkg::*;

  // Issue side
  logic     issue_valid;
  logic     issue_ok;
  logic     read_ok;
  opcode_t  opcode;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  imm_t     imm;
  reg_idx_t read_idx;
  data_t    rs1_data;
  data_t    rs2_data;
  data_t    read_data;

  // Writeback side
  logic                             alu_wb_valid;
  reg_idx_t                         alu_wb_rd;
  data_t                            alu_wb_data;
  logic                             mul_wb_valid;
  reg_idx_t                         mul_wb_rd;
  data_t                            mul_wb_data;
  logic [`EXU_MUL_STAGES-1:0]       mul_stage_valid;
  reg_idx_t [`EXU_MUL_STAGES-1:0]   mul_stage_rd;

  exu_wb_slave u_wb_slave (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .issue_ok_i    (issue_ok),
    .read_ok_i     (read_ok),
    .rd_data_i     (read_data),
    .issue_valid_o (issue_valid),
    .opcode_o      (opcode),
    .rd_o          (rd),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .imm_o         (imm),
    .read_idx_o    (read_idx)
  );

  exu_hazard u_hazard (
    .issue_valid_i (issue_valid),
    .opcode_i      (opcode),
    .rd_i          (rd),
    .rs1_i         (rs1),
    .rs2_i         (rs2),
    .read_idx_i    (read_idx),
    .alu_busy_i    (alu_wb_valid),
    .alu_rd_i      (alu_wb_rd),
    .mul_valid_i   (mul_stage_valid),
    .mul_rd_i      (mul_stage_rd),
    .issue_ok_o    (issue_ok),
    .read_ok_o     (read_ok)
  );

  // issue_ok is the accepted-write pulse
  exu_alu u_alu (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .issue_i    (issue_ok),
    .opcode_i   (opcode),
    .rd_i       (rd),
    .imm_i      (imm),
    .a_i        (rs1_data),
    .b_i        (rs2_data),
    .wb_valid_o (alu_wb_valid),
    .wb_rd_o    (alu_wb_rd),
    .wb_data_o  (alu_wb_data)
  );

  exu_mul_pipe u_mul_pipe (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_i       (issue_ok),
    .opcode_i      (opcode),
    .rd_i          (rd),
    .a_i           (rs1_data),
    .b_i           (rs2_data),
    .stage_valid_o (mul_stage_valid),
    .stage_rd_o    (mul_stage_rd),
    .wb_valid_o    (mul_wb_valid),
    .wb_rd_o       (mul_wb_rd),
    .wb_data_o     (mul_wb_data)
  );

  exu_regfile u_regfile (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .dbg_idx_i      (read_idx),
    .rs1_data_o     (rs1_data),
    .rs2_data_o     (rs2_data),
    .dbg_data_o     (read_data),
    .alu_wb_valid_i (alu_wb_valid),
    .alu_wb_rd_i    (alu_wb_rd),
    .alu_wb_data_i  (alu_wb_data),
    .mul_wb_valid_i (mul_wb_valid),
    .mul_wb_rd_i    (mul_wb_rd),
    .mul_wb_data_i  (mul_wb_data)
  );

endmodule

// ==== bench/exu_chk.sv ====
`timescale 1ns/1ps

module exu_chk (
  input logic           clk_i,
  input logic           rst_i,
  input logic           wb_cyc_i,
  input logic           wb_stb_i,
  input logic           wb_ack_i,
  input logic           alu_wb_valid_i,
  input logic           mul_wb_valid_i,
  input exu_pkg::data_t r0_i
);

  // Ack answers a request that was present at the accepting edge
  ack_needs_request: assert property (@(posedge clk_i) disable iff (!rst_i)
    $rose(wb_ack_i) |-> $past(wb_cyc_i && wb_stb_i))
    else $error("ack raised without a bus request");

  ack_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_ack_i |=> !wb_ack_i)
    else $error("ack held for two cycles");

  one_writeback: assert property (@(posedge clk_i) disable iff (!rst_i)
    !(alu_wb_valid_i && mul_wb_valid_i))
    else $error("ALU and multiply writebacks in the same cycle");

  r0_zero: assert property (@(posedge clk_i) disable iff (!rst_i)
    r0_i == '0)
    else $error("register 0 was written");

endmodule

bind exu_top exu_chk u_chk (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .wb_cyc_i       (wb_cyc_i),
  .wb_stb_i       (wb_stb_i),
  .wb_ack_i       (wb_ack_o),
  .alu_wb_valid_i (alu_wb_valid),
  .mul_wb_valid_i (mul_wb_valid),
  .r0_i           (u_regfile.regs_q[0])
);

// ==== bench/exu_tb.sv ====
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_tb;
  import exu_pkg::*;

  // Operation count of each test in order
  localparam int NUM_OPS     = 16 + 28 + 51 + 43 + 416;
  localparam int CYCLE_LIMIT = 40 * NUM_OPS + 100;

  logic        clk_i;
  logic        rst_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  wb_addr_t    wb_adr_i;
  data_t       wb_dat_i;
  data_t       wb_dat_o;
  logic        wb_ack_o;

  logic [31:0] lfsr;
  data_t       model [`EXU_NREGS];
  int          errors;
  int          checks;
  int          cycles = 0;

  exu_top dut_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic data_t make_op(input logic [3:0] op, input logic [3:0] rd,
                                    input logic [3:0] rs1, input logic [3:0] rs2,
                                    input logic [15:0] imm);
    return {op, rd, rs1, rs2, imm};
  endfunction

  function automatic data_t rand_op(input logic [3:0] op, input int reg_bits);
    logic [3:0]  rd;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [15:0] imm;
    rd  = 4'(rand_bits(reg_bits));
    rs1 = 4'(rand_bits(reg_bits));
    rs2 = 4'(rand_bits(reg_bits));
    imm = (op == OP_LI) ? 16'(rand_bits(16)) : 16'h0;
    return make_op(op, rd, rs1, rs2, imm);
  endfunction

  // In-order reference where unknown opcodes and NOP change nothing
  function automatic void model_apply(input data_t w);
    data_t a;
    data_t b;
    data_t r;
    a = model[w[23:20]];
    b = model[w[19:16]];
    case (w[31:28])
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_LI:   r = {16'h0, w[15:0]};
      OP_MUL:  r = a * b;
      default: return;
    endcase
    if (w[27:24] != 4'd0) begin
      model[w[27:24]] = r;
    end
  endfunction

  // Second idle edge sees cyc and stb low with the ack already gone
  task automatic bus_idle();
    repeat (2) @(negedge clk_i);
  endtask

  task automatic wb_write(input data_t w);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_dat_i = w;
    @(negedge clk_i);
    while (!wb_ack_o) begin
      @(negedge clk_i);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    bus_idle();
  endtask

  task automatic wb_read(input logic [3:0] idx, output data_t d);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = idx;
    @(negedge clk_i);
    while (!wb_ack_o) begin
      @(negedge clk_i);
    end
    d        = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    bus_idle();
  endtask

  task automatic issue_op(input data_t w);
    wb_write(w);
    model_apply(w);
  endtask

  task automatic check_reg(input string test, input logic [3:0] idx);
    data_t got;
    wb_read(idx, got);
    checks++;
    assert (got === model[idx])
      else begin
        $display("CHECK FAILED %s r%0d: expected %h, actual %h", test, idx, model[idx], got);
        errors++;
      end
  endtask

  task automatic check_all(input string test);
    for (int i = 0; i < `EXU_NREGS; i++) begin
      check_reg(test, 4'(i));
    end
  endtask

  task automatic seed_regs();
    for (int i = 1; i < `EXU_NREGS; i++) begin
      issue_op(make_op(OP_LI, 4'(i), 4'd0, 4'd0, 16'(rand_bits(16))));
    end
  endtask

  task automatic end_test(input string test, input int base);
    $display("test %s done with %0d errors", test, errors - base);
  endtask

  initial begin
    int         base;
    data_t      w;
    logic [3:0] op;
    lfsr     = 32'h8a9b;
    errors   = 0;
    checks   = 0;
    rst_i    = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    for (int i = 0; i < `EXU_NREGS; i++) begin
      model[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b1;

    base = errors;
    check_all("reset");
    end_test("reset", base);

    base = errors;
    for (int n = 0; n < 12; n++) begin
      issue_op(rand_op(OP_LI, 4));
    end
    check_all("load_imm");
    end_test("load_imm", base);

    base = errors;
    seed_regs();
    for (int n = 0; n < 20; n++) begin
      op = 4'(rand_bits(3) % 5);
      issue_op(rand_op(op, 4));
    end
    check_all("alu_ops");
    end_test("alu_ops", base);

    base = errors;
    seed_regs();
    for (int n = 0; n < 6; n++) begin
      // First destination sits in r8..r15 out of reach of the second multiply
      w = rand_op(OP_MUL, 3);
      w[27] = 1'b1;
      issue_op(w);
      issue_op(rand_op(OP_MUL, 3));
    end
    check_all("multiply");
    end_test("multiply", base);

    // Narrow register range to force RAW and WAW chains on multiply results
    base = errors;
    for (int n = 0; n < 200; n++) begin
      op = 4'(rand_bits(3));
      w  = rand_op(op, 3);
      issue_op(w);
      if (op == OP_MUL) begin
        check_reg("dependences", w[27:24]);
      end
    end
    check_all("dependences");
    end_test("dependences", base);

    $display("5 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+include
verilog/exu_pkg.sv
verilog/exu_wb_slave.sv
verilog/exu_hazard.sv
verilog/exu_alu.sv
verilog/exu_mul_pipe.sv
verilog/exu_regfile.sv
verilog/exu_top.sv
bench/exu_chk.sv
bench/exu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the exu_tb regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module exu_tb -o exu_sim \
  && ./obj_dir/exu_sim | tee /dev/stderr | grep "Regression passed" > /dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
